/* Bender.yml */
package:
  name: reservation_station

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rs_pkg.sv
      - rtl/rs_slot_if.sv
      - rtl/rs_dispatch_alloc.sv
      - rtl/rs_slot.sv
      - rtl/rs_issue_select.sv
      - rtl/reservation_station.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - testbench/rs_clock_gen.sv
      - testbench/rs_checker.sv
      - testbench/rs_tb.sv

/* rtl/reservation_station.sv */
`timescale 1ns/100ps
`include "rs_settings.svh"

module reservation_station (
    input  logic                                    clock,
    input  logic                                    reset,

    input  logic                                    dispatch_valid,
    output logic                                    dispatch_ready,
    input  rs_pkg::rs_payload_t                     dispatch_payload,

    input  logic                                    cdb_valid,
    input  logic [`RS_TAG_W-1:0]                    cdb_tag,

    input  rs_pkg::br_task_e                        br_task,
    input  logic [`RS_BR_MASK_W-1:0]                br_id,

    input  logic [`RS_FU_COUNT-1:0]                 fu_busy,
    output logic [`RS_FU_COUNT-1:0]                 issue_valid,
    output rs_pkg::rs_payload_t [`RS_FU_COUNT-1:0]  issue_payload
);

    rs_slot_if slot_bus [`RS_DEPTH] ();

    rs_dispatch_alloc alloc_i (
        .clock            (clock),
        .reset            (reset),
        .dispatch_valid   (dispatch_valid),
        .dispatch_payload (dispatch_payload),
        .cdb_valid        (cdb_valid),
        .cdb_tag          (cdb_tag),
        .dispatch_ready   (dispatch_ready),
        .slots            (slot_bus)
    );

    genvar g;
    generate
        for (g = 0; g < `RS_DEPTH; g++) begin : g_slot
            rs_slot slot_i (
                .clock     (clock),
                .reset     (reset),
                .cdb_valid (cdb_valid),
                .cdb_tag   (cdb_tag),
                .br_task   (br_task),
                .br_id     (br_id),
                .port      (slot_bus[g])
            );
        end
    endgenerate

    rs_issue_select select_i (
        .clock         (clock),
        .reset         (reset),
        .fu_busy       (fu_busy),
        .issue_valid   (issue_valid),
        .issue_payload (issue_payload),
        .slots         (slot_bus)
    );

endmodule

/* rtl/rs_dispatch_alloc.sv */
`timescale 1ns/100ps
`include "rs_settings.svh"

module rs_dispatch_alloc (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  rs_pkg::rs_payload_t   dispatch_payload,
    input  logic                  cdb_valid,
    input  logic [`RS_TAG_W-1:0]  cdb_tag,
    output logic                  dispatch_ready,
    rs_slot_if.alloc              slots [`RS_DEPTH]
);

    logic [`RS_DEPTH-1:0]          free_vec;
    logic [`RS_DEPTH-1:0]          write_vec;
    logic [$clog2(`RS_DEPTH)-1:0]  free_idx;
    logic                          any_free;
    logic                          accept;
    rs_pkg::rs_payload_t           staged;

    genvar g;
    generate
        for (g = 0; g < `RS_DEPTH; g++) begin : g_slot_link
            assign free_vec[g]            = slots[g].free;
            assign slots[g].write_en      = write_vec[g];
            assign slots[g].write_payload = staged;
        end
    endgenerate

    // Scan from the top so the lowest free index is the one left standing
    always_comb begin
        any_free = 1'b0;
        free_idx = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (free_vec[i]) begin
                any_free = 1'b1;
                free_idx = i[$clog2(`RS_DEPTH)-1:0];
            end
        end
    end

    assign dispatch_ready = any_free;
    assign accept         = dispatch_valid && any_free;
    assign write_vec      = accept ? (`RS_DEPTH'(1) << free_idx) : '0;

    // A tag on the result bus this cycle would be missed by the slot otherwise
    always_comb begin
        staged = dispatch_payload;
        if (cdb_valid && dispatch_payload.src1_tag == cdb_tag) begin
            staged.src1_ready = 1'b1;
        end
        if (cdb_valid && dispatch_payload.src2_tag == cdb_tag) begin
            staged.src2_ready = 1'b1;
        end
    end

    a_write_one_free: assert property (@(posedge clock) disable iff (reset)
        $onehot0(write_vec) && ((write_vec & ~free_vec) == '0));

endmodule

/* rtl/rs_issue_select.sv */
`timescale 1ns/100ps
`include "rs_settings.svh"

module rs_issue_select (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic [`RS_FU_COUNT-1:0]                   fu_busy,
    output logic [`RS_FU_COUNT-1:0]                   issue_valid,
    output rs_pkg::rs_payload_t [`RS_FU_COUNT-1:0]    issue_payload,
    rs_slot_if.select                                 slots [`RS_DEPTH]
);

    logic [`RS_DEPTH-1:0]                     req_vec;
    logic [`RS_DEPTH-1:0]                     grant_vec;
    logic [`RS_FU_COUNT-1:0][`RS_DEPTH-1:0]   class_grant;
    rs_pkg::fu_class_e                        class_vec [`RS_DEPTH];
    rs_pkg::rs_payload_t                      payload_arr [`RS_DEPTH];

    genvar g;
    generate
        for (g = 0; g < `RS_DEPTH; g++) begin : g_slot_link
            assign req_vec[g]     = slots[g].request;
            assign class_vec[g]   = slots[g].request_class;
            assign payload_arr[g] = slots[g].payload;
            assign slots[g].grant = grant_vec[g];
        end
    endgenerate

    // One fixed-priority pick per class, lowest index first
    always_comb begin
        logic found;
        class_grant   = '0;
        issue_valid   = '0;
        issue_payload = '0;
        for (int c = 0; c < `RS_FU_COUNT; c++) begin
            found = 1'b0;
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (!found && !fu_busy[c] && req_vec[i] &&
                    class_vec[i] == rs_pkg::fu_class_e'(c)) begin
                    found             = 1'b1;
                    class_grant[c][i] = 1'b1;
                    issue_valid[c]    = 1'b1;
                    issue_payload[c]  = payload_arr[i];
                end
            end
        end
    end

    always_comb begin
        grant_vec = '0;
        for (int c = 0; c < `RS_FU_COUNT; c++) begin
            grant_vec |= class_grant[c];
        end
    end

    // A granted entry leaves the station, so it never wins a second time
    a_one_grant_per_slot: assert property (@(posedge clock) disable iff (reset)
        (grant_vec != '0) |=> ((req_vec & $past(grant_vec)) == '0));

    a_no_issue_when_busy: assert property (@(posedge clock) disable iff (reset)
        (issue_valid & fu_busy) == '0);

endmodule

/* rtl/rs_pkg.sv */
`include "rs_settings.svh"

package rs_pkg;

    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_MUL   = 3'd3,
        OP_LOAD  = 3'd4,
        OP_STORE = 3'd5
    } opcode_e;

    // Also the index of the issue port for each class
    typedef enum logic [1:0] {
        FU_ALU  = 2'd0,
        FU_MULT = 2'd1,
        FU_MEM  = 2'd2
    } fu_class_e;

    typedef enum logic [1:0] {
        SLOT_FREE  = 2'd0,
        SLOT_WAIT  = 2'd1,
        SLOT_READY = 2'd2
    } slot_state_e;

    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_CLEAR  = 2'd1,
        BR_SQUASH = 2'd2
    } br_task_e;

    typedef struct packed {
        opcode_e                   opcode;
        logic [`RS_TAG_W-1:0]      dest_tag;
        logic [`RS_TAG_W-1:0]      src1_tag;
        logic                      src1_ready;
        logic [`RS_TAG_W-1:0]      src2_tag;
        logic                      src2_ready;
        logic [`RS_BR_MASK_W-1:0]  br_mask;
    } rs_payload_t;

endpackage

/* rtl/rs_settings.svh */
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// Number of station entries
`define RS_DEPTH 8

// Physical register tag width
`define RS_TAG_W 6

// One mask bit per unresolved branch
`define RS_BR_MASK_W 4

// ALU, multiplier and memory
`define RS_FU_COUNT 3

`endif

/* rtl/rs_slot.sv */
`timescale 1ns/100ps
`include "rs_settings.svh"

module rs_slot (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      cdb_valid,
    input  logic [`RS_TAG_W-1:0]      cdb_tag,
    input  rs_pkg::br_task_e          br_task,
    input  logic [`RS_BR_MASK_W-1:0]  br_id,
    rs_slot_if.entry                  port
);

    rs_pkg::slot_state_e  state;
    rs_pkg::slot_state_e  state_d;
    rs_pkg::rs_payload_t  entry_q;
    rs_pkg::rs_payload_t  entry_d;
    logic                 occupied;
    logic                 squash_hit;

    assign occupied   = (state != rs_pkg::SLOT_FREE);
    assign squash_hit = occupied && (br_task == rs_pkg::BR_SQUASH) &&
                        ((entry_q.br_mask & br_id) != '0);

    always_comb begin
        entry_d = entry_q;
        state_d = state;

        if (occupied && cdb_valid) begin
            if (entry_q.src1_tag == cdb_tag) begin
                entry_d.src1_ready = 1'b1;
            end
            if (entry_q.src2_tag == cdb_tag) begin
                entry_d.src2_ready = 1'b1;
            end
        end

        if (br_task == rs_pkg::BR_CLEAR) begin
            entry_d.br_mask = entry_q.br_mask & ~br_id;
        end

        // Writes only reach free slots, grants only ready ones
        if (port.write_en) begin
            entry_d = port.write_payload;
            state_d = (port.write_payload.src1_ready && port.write_payload.src2_ready) ?
                      rs_pkg::SLOT_READY : rs_pkg::SLOT_WAIT;
        end else if (squash_hit || port.grant) begin
            state_d = rs_pkg::SLOT_FREE;
        end else if (state == rs_pkg::SLOT_WAIT && entry_d.src1_ready && entry_d.src2_ready) begin
            state_d = rs_pkg::SLOT_READY;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= rs_pkg::SLOT_FREE;
        end else begin
            state <= state_d;
        end
    end

    always_ff @(posedge clock) begin
        entry_q <= entry_d;
    end

    always_comb begin
        unique case (entry_q.opcode)
            rs_pkg::OP_MUL:                  port.request_class = rs_pkg::FU_MULT;
            rs_pkg::OP_LOAD, rs_pkg::OP_STORE: port.request_class = rs_pkg::FU_MEM;
            default:                         port.request_class = rs_pkg::FU_ALU;
        endcase
    end

    assign port.free    = !occupied;
    assign port.request = (state == rs_pkg::SLOT_READY) && !squash_hit;
    assign port.payload = entry_q;

    a_grant_needs_request: assert property (@(posedge clock) disable iff (reset)
        port.grant |-> port.request);

endmodule

/* rtl/rs_slot_if.sv */
`timescale 1ns/100ps

interface rs_slot_if;

    // Allocator to slot
    logic                 write_en;
    rs_pkg::rs_payload_t  write_payload;

    // Slot to allocator and selector
    logic                 free;
    logic                 request;
    rs_pkg::fu_class_e    request_class;
    rs_pkg::rs_payload_t  payload;

    // Selector to slot
    logic                 grant;

    modport alloc (
        input  free,
        output write_en,
        output write_payload
    );

    // The slot's own view, joining its outputs with the grant it receives
    modport entry (
        input  write_en,
        input  write_payload,
        input  grant,
        output free,
        output request,
        output request_class,
        output payload
    );

    modport select (
        input  request,
        input  request_class,
        input  payload,
        output grant
    );

endinterface

/* sim.f */
+incdir+rtl
rtl/rs_pkg.sv
rtl/rs_slot_if.sv
rtl/rs_dispatch_alloc.sv
rtl/rs_slot.sv
rtl/rs_issue_select.sv
rtl/reservation_station.sv
testbench/rs_clock_gen.sv
testbench/rs_checker.sv
testbench/rs_tb.sv

/* testbench/rs_checker.sv */
`timescale 1ns/100ps
`include "rs_settings.svh"

module rs_checker (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    dispatch_valid,
    input  logic                                    dispatch_ready,
    input  rs_pkg::rs_payload_t                     dispatch_payload,
    input  logic                                    cdb_valid,
    input  logic [`RS_TAG_W-1:0]                    cdb_tag,
    input  rs_pkg::br_task_e                        br_task,
    input  logic [`RS_BR_MASK_W-1:0]                br_id,
    input  logic [`RS_FU_COUNT-1:0]                 fu_busy,
    input  logic [`RS_FU_COUNT-1:0]                 issue_valid,
    input  rs_pkg::rs_payload_t [`RS_FU_COUNT-1:0]  issue_payload,
    output int                                      pending,
    output int                                      errors
);

    // Pending instructions, kept in the slot order the station fills
    logic                 held [`RS_DEPTH];
    rs_pkg::rs_payload_t  model [`RS_DEPTH];
    logic                 issued [2**`RS_TAG_W];

    function automatic rs_pkg::fu_class_e class_of(rs_pkg::opcode_e op);
        case (op)
            rs_pkg::OP_MUL:                    return rs_pkg::FU_MULT;
            rs_pkg::OP_LOAD, rs_pkg::OP_STORE: return rs_pkg::FU_MEM;
            default:                           return rs_pkg::FU_ALU;
        endcase
    endfunction

    function automatic rs_pkg::rs_payload_t woken(rs_pkg::rs_payload_t p);
        if (cdb_valid && p.src1_tag == cdb_tag) p.src1_ready = 1'b1;
        if (cdb_valid && p.src2_tag == cdb_tag) p.src2_ready = 1'b1;
        return p;
    endfunction

    task automatic value_error(string name, logic [63:0] got, logic [63:0] want);
        $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, want);
        errors++;
    endtask

    initial begin
        pending = 0;
        errors  = 0;
        foreach (held[i]) held[i] = 1'b0;
        foreach (issued[t]) issued[t] = 1'b0;
    end

    always @(posedge clock) begin : model_step
        int   pick [`RS_FU_COUNT];
        int   into;
        logic hit;
        if (reset) begin
            foreach (held[i]) held[i] = 1'b0;
        end else begin
            into = -1;
            for (int i = `RS_DEPTH - 1; i >= 0; i--) if (!held[i]) into = i;
            if (dispatch_ready !== (into >= 0)) begin
                value_error("dispatch_ready", dispatch_ready, into >= 0);
            end
            for (int c = 0; c < `RS_FU_COUNT; c++) begin
                pick[c] = -1;
                for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
                    hit = (br_task == rs_pkg::BR_SQUASH) && ((model[i].br_mask & br_id) != '0);
                    if (held[i] && !hit && !fu_busy[c] && model[i].src1_ready &&
                        model[i].src2_ready && class_of(model[i].opcode) == c) begin
                        pick[c] = i;
                    end
                end
                if (issue_valid[c] !== (pick[c] >= 0)) begin
                    value_error($sformatf("issue_valid[%0d]", c), issue_valid[c], pick[c] >= 0);
                end else if (pick[c] >= 0 && issue_payload[c] !== model[pick[c]]) begin
                    value_error($sformatf("issue_payload[%0d]", c), issue_payload[c],
                                model[pick[c]]);
                end
                if (issue_valid[c] === 1'b1 && issued[issue_payload[c].dest_tag] === 1'b1) begin
                    $display("** Error: instruction with tag 0x%0h issued a second time",
                             issue_payload[c].dest_tag);
                    errors++;
                end
                if (issue_valid[c] === 1'b1) issued[issue_payload[c].dest_tag] = 1'b1;
                // An entry the station did not hand over stays pending
                if (pick[c] >= 0 && issue_valid[c] === 1'b1) held[pick[c]] = 1'b0;
            end
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (br_task == rs_pkg::BR_SQUASH && (model[i].br_mask & br_id) != '0) begin
                    held[i] = 1'b0;
                end
                if (br_task == rs_pkg::BR_CLEAR) model[i].br_mask &= ~br_id;
                if (held[i]) model[i] = woken(model[i]);
            end
            // A result on the bus in the dispatch cycle counts for the new entry
            if (dispatch_valid && into >= 0) begin
                model[into] = woken(dispatch_payload);
                held[into]  = 1'b1;
                issued[dispatch_payload.dest_tag] = 1'b0;
            end
        end
        pending = 0;
        foreach (held[i]) pending += held[i];
    end

endmodule

/* testbench/rs_clock_gen.sv */
`timescale 1ns/100ps

module rs_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Released just after an edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clock);
        #2 reset = 1'b0;
    end

endmodule

/* testbench/rs_tb.sv */
`timescale 1ns/100ps
`include "rs_settings.svh"

module rs_tb;

    // Reset, then the five stimulus tests with their drains
    localparam int RUN_CYCLES = 17 + 30 + 40 + 50 + 40 + 260;
    localparam int WAIT_LIMIT = 100;

    logic                                    clock;
    logic                                    reset;
    logic                                    dispatch_valid;
    logic                                    dispatch_ready;
    rs_pkg::rs_payload_t                     dispatch_payload;
    logic                                    cdb_valid;
    logic [`RS_TAG_W-1:0]                    cdb_tag;
    rs_pkg::br_task_e                        br_task;
    logic [`RS_BR_MASK_W-1:0]                br_id;
    logic [`RS_FU_COUNT-1:0]                 fu_busy;
    logic [`RS_FU_COUNT-1:0]                 issue_valid;
    rs_pkg::rs_payload_t [`RS_FU_COUNT-1:0]  issue_payload;
    int                                      pending;
    int                                      check_errors;
    int                                      tb_errors;
    int                                      tests_run;
    int                                      tests_failed;
    int                                      errors_before;
    logic [31:0]                             lfsr_state;
    logic [`RS_TAG_W-1:0]                    next_tag;

    rs_clock_gen clock_gen_i (.clock(clock), .reset(reset));
    reservation_station dut_i (.*);
    rs_checker checker_i (.*, .errors(check_errors));

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Pulsed inputs fall back to idle in every new cycle
    task automatic next_cycle();
        @(posedge clock);
        #2;
        dispatch_valid = 1'b0;
        cdb_valid      = 1'b0;
        br_task        = rs_pkg::BR_NONE;
        br_id          = '0;
    endtask

    task automatic send(rs_pkg::opcode_e op, logic [`RS_TAG_W-1:0] s1, logic r1,
                        logic [`RS_TAG_W-1:0] s2, logic r2, logic [`RS_BR_MASK_W-1:0] mask);
        int waited;
        waited = 0;
        while (!dispatch_ready && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!dispatch_ready) begin
            $display("** Error: dispatch_ready stayed low for %0d cycles", WAIT_LIMIT);
            tb_errors++;
        end else begin
            dispatch_valid   = 1'b1;
            dispatch_payload = '{op, next_tag, s1, r1, s2, r2, mask};
            next_tag++;
            next_cycle();
        end
    endtask

    task automatic broadcast(logic [`RS_TAG_W-1:0] tag);
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        next_cycle();
    endtask

    task automatic resolve(rs_pkg::br_task_e kind, logic [`RS_BR_MASK_W-1:0] id);
        br_task = kind;
        br_id   = id;
        next_cycle();
    endtask

    task automatic drain();
        int waited;
        fu_busy = '0;
        waited  = 0;
        while (pending != 0 && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (pending != 0) begin
            $display("** Error: %0d instructions were never issued", pending);
            tb_errors++;
        end
    endtask

    task automatic finish_test(string name);
        int found;
        found = check_errors + tb_errors - errors_before;
        tests_run++;
        if (found != 0) tests_failed++;
        $display("test %-16s %s, %0d errors", name, (found == 0) ? "ok" : "failed", found);
        errors_before = check_errors + tb_errors;
        next_tag      = '0;
    endtask

    initial begin
        #((RUN_CYCLES + 100) * 20);
        $display("Watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        rs_pkg::rs_payload_t p;
        int                  sent;
        dispatch_valid   = 1'b0;
        dispatch_payload = '0;
        cdb_valid        = 1'b0;
        cdb_tag          = '0;
        br_task          = rs_pkg::BR_NONE;
        br_id            = '0;
        fu_busy          = '0;
        tb_errors        = 0;
        tests_run        = 0;
        tests_failed     = 0;
        errors_before    = 0;
        next_tag         = '0;
        lfsr_state       = 32'h4cc1;

        @(negedge reset);
        next_cycle();
        finish_test("reset");

        for (int k = 0; k < 6; k++) begin
            send(rs_pkg::opcode_e'(k), `RS_TAG_W'(k), 1'b1, `RS_TAG_W'(k + 8), 1'b1, '0);
        end
        drain();
        finish_test("ready operands");

        for (int k = 0; k < 4; k++) begin
            send(rs_pkg::opcode_e'(k + 2), `RS_TAG_W'(32 + k), 1'b0,
                 `RS_TAG_W'(48 + k), k[0], '0);
        end
        repeat (3) next_cycle();
        for (int k = 0; k < 4; k++) begin
            broadcast(`RS_TAG_W'(32 + k));
            broadcast(`RS_TAG_W'(48 + k));
        end
        // Tag on the bus in the dispatch cycle itself
        cdb_valid = 1'b1;
        cdb_tag   = `RS_TAG_W'(56);
        send(rs_pkg::OP_SUB, `RS_TAG_W'(56), 1'b0, `RS_TAG_W'(57), 1'b1, '0);
        drain();
        finish_test("wakeup");

        fu_busy[rs_pkg::FU_ALU] = 1'b1;
        send(rs_pkg::OP_MUL, `RS_TAG_W'(1), 1'b1, `RS_TAG_W'(2), 1'b1, '0);
        send(rs_pkg::OP_MUL, `RS_TAG_W'(3), 1'b1, `RS_TAG_W'(4), 1'b1, '0);
        for (int k = 0; k < `RS_DEPTH; k++) begin
            send(rs_pkg::opcode_e'(k % 3), `RS_TAG_W'(k), 1'b1, `RS_TAG_W'(k + 1), 1'b1, '0);
        end
        repeat (4) next_cycle();
        drain();
        finish_test("busy and full");

        for (int k = 0; k < 4; k++) begin
            send(rs_pkg::OP_ADD, `RS_TAG_W'(60), 1'b0, `RS_TAG_W'(61), 1'b1, 4'b0001);
        end
        send(rs_pkg::OP_MUL, `RS_TAG_W'(60), 1'b0, `RS_TAG_W'(62), 1'b1, 4'b0011);
        send(rs_pkg::OP_LOAD, `RS_TAG_W'(60), 1'b0, `RS_TAG_W'(62), 1'b1, 4'b0010);
        resolve(rs_pkg::BR_SQUASH, 4'b0001);
        resolve(rs_pkg::BR_CLEAR, 4'b0010);
        // Squash lands in the first cycle this one could issue
        send(rs_pkg::OP_AND, `RS_TAG_W'(1), 1'b1, `RS_TAG_W'(2), 1'b1, 4'b0100);
        resolve(rs_pkg::BR_SQUASH, 4'b0100);
        broadcast(`RS_TAG_W'(60));
        drain();
        finish_test("branch");

        sent = 0;
        for (int n = 0; n < 120; n++) begin
            fu_busy = `RS_FU_COUNT'(rand_bits(`RS_FU_COUNT));
            if (rand_bits(3) == 0) begin
                br_task = rand_bits(1) ? rs_pkg::BR_SQUASH : rs_pkg::BR_CLEAR;
                br_id   = `RS_BR_MASK_W'(1) << rand_bits(2);
            end
            if (rand_bits(1)) begin
                cdb_valid = 1'b1;
                cdb_tag   = `RS_TAG_W'(rand_bits(`RS_TAG_W));
            end
            if (dispatch_ready && rand_bits(1) && sent < 2**`RS_TAG_W) begin
                p.opcode     = rs_pkg::opcode_e'(3'(rand_bits(3) % 6));
                p.dest_tag   = next_tag;
                p.src1_tag   = `RS_TAG_W'(rand_bits(`RS_TAG_W));
                p.src1_ready = 1'(rand_bits(1));
                p.src2_tag   = `RS_TAG_W'(rand_bits(`RS_TAG_W));
                p.src2_ready = 1'(rand_bits(1));
                p.br_mask    = `RS_BR_MASK_W'(rand_bits(`RS_BR_MASK_W)) & ~br_id;
                dispatch_valid   = 1'b1;
                dispatch_payload = p;
                next_tag++;
                sent++;
            end
            next_cycle();
        end
        fu_busy = '0;
        for (int t = 0; t < 2**`RS_TAG_W; t++) begin
            broadcast(`RS_TAG_W'(t));
        end
        drain();
        finish_test("random mix");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 check_errors + tb_errors);
        if (tests_failed == 0 && check_errors + tb_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
